// File: hw/axi_regs_cfg.svh
`ifndef AXI_REGS_CFG_SVH
`define AXI_REGS_CFG_SVH

// sizing of the routing configuration block
// bus widths follow the AXI-Lite slave port that software uses

// byte address width of the AXI-Lite slave port
`define AXI_REGS_ADDR_W 32

// data width of the AXI-Lite slave port, one strobe bit per byte
`define AXI_REGS_DATA_W 32

// number of master ports of the interconnect node
// each master owns a group of address regions
`define AXI_REGS_N_MASTER 4

// number of address regions held for every master port
`define AXI_REGS_N_REGION 2

// number of slave ports, each one has a connectivity map word
// the map word carries one enable bit per master port
`define AXI_REGS_N_SLAVE 4

`endif

// File: hw/axi_lite_pkg.sv
`default_nettype none

`include "axi_regs_cfg.svh"

// types of the AXI-Lite slave bus
package axi_lite_pkg;

  // byte address as seen on AW and AR
  typedef logic [`AXI_REGS_ADDR_W-1:0] addr_t;
  typedef logic [`AXI_REGS_DATA_W-1:0] data_t;
  // one enable per byte lane of data_t
  typedef logic [`AXI_REGS_DATA_W/8-1:0] strb_t;
  typedef logic [1:0] resp_t;

  // this block never signals an error, every response is OKAY
  localparam resp_t RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

// File: hw/route_map_pkg.sv
`default_nettype none

`include "axi_regs_cfg.svh"

// types of the routing register map
package route_map_pkg;

  // word index taken from byte address bits 12 down to 2
  typedef logic [10:0] word_addr_t;

  // top bit of the word index picks the connectivity map words
  localparam int MAP_SEL_BIT = 10;

  // low two bits of a region word index give the slot inside the region
  typedef enum logic [1:0] {
    SLOT_START = 2'd0,
    SLOT_END   = 2'd1,
    SLOT_RULE  = 2'd2,
    SLOT_RSVD  = 2'd3
  } slot_e;

  // one stored word seen either as a full address or as a rule word
  // start and end slots use the address view
  // rule slots only keep the valid bit in position 0
  typedef union packed {
    axi_lite_pkg::addr_t addr;
    struct packed {
      logic [`AXI_REGS_ADDR_W-2:0] rsvd;
      logic                        valid;
    } rule;
  } cfg_word_u;

  // read and write channels share this decode of the byte address
  // the two lowest address bits are ignored, accesses are word wide
  function automatic word_addr_t word_of(input axi_lite_pkg::addr_t byte_addr);
    word_addr_t word;
    word = byte_addr[12:2];
    return word;
  endfunction

endpackage

`default_nettype wire

// File: hw/axi_lite_write_port.sv
`timescale 1ns/1ps
`default_nettype none

// AXI-Lite write side of the configuration block
// AW and W are taken independently and in any order
// once both are held, one register write is issued and B is raised
module axi_lite_write_port (
  input  wire logic                 s_axi_aclk,
  input  wire logic                 s_axi_aresetn,
  input  axi_lite_pkg::addr_t       s_axi_awaddr_i,
  input  wire logic                 s_axi_awvalid_i,
  output logic                      s_axi_awready_o,
  input  axi_lite_pkg::data_t       s_axi_wdata_i,
  input  axi_lite_pkg::strb_t       s_axi_wstrb_i,
  input  wire logic                 s_axi_wvalid_i,
  output logic                      s_axi_wready_o,
  output logic                      s_axi_bvalid_o,
  output axi_lite_pkg::resp_t       s_axi_bresp_o,
  input  wire logic                 s_axi_bready_i,
  output logic                      wr_en_o,
  output route_map_pkg::word_addr_t wr_word_o,
  output axi_lite_pkg::data_t       wr_data_o,
  output axi_lite_pkg::strb_t       wr_strb_o
);

  // done flags mark a captured address or data beat
  logic aw_done_q;
  logic w_done_q;
  logic bvalid_q;
  // high for the one cycle after the B handshake
  logic b_done_q;

  logic aw_hs;
  logic w_hs;
  logic b_hs;

  route_map_pkg::word_addr_t waddr_q;
  axi_lite_pkg::data_t       wdata_q;
  axi_lite_pkg::strb_t       wstrb_q;

  // each channel is ready exactly while nothing has been captured on it
  assign s_axi_awready_o = !aw_done_q;
  assign s_axi_wready_o  = !w_done_q;

  assign aw_hs = s_axi_awvalid_i && !aw_done_q;
  assign w_hs  = s_axi_wvalid_i && !w_done_q;
  assign b_hs  = bvalid_q && s_axi_bready_i;

  // fires in the cycle after the later of the two captures
  // bvalid rises on the same edge that updates the register file
  assign wr_en_o = aw_done_q && w_done_q && !bvalid_q && !b_done_q;

  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn)
  begin
    if (!s_axi_aresetn)
    begin
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
      bvalid_q  <= 1'b0;
      b_done_q  <= 1'b0;
    end
    else
    begin
      // captures stay locked until the edge after B is taken
      if (aw_hs)
      begin
        aw_done_q <= 1'b1;
      end
      else if (b_done_q)
      begin
        aw_done_q <= 1'b0;
      end

      if (w_hs)
      begin
        w_done_q <= 1'b1;
      end
      else if (b_done_q)
      begin
        w_done_q <= 1'b0;
      end

      // a stalled bready simply keeps the response up
      if (wr_en_o)
      begin
        bvalid_q <= 1'b1;
      end
      else if (b_hs)
      begin
        bvalid_q <= 1'b0;
      end

      b_done_q <= b_hs;
    end
  end

  // address and data payload, only meaningful while the done flags are set
  always_ff @(posedge s_axi_aclk)
  begin
    if (aw_hs)
    begin
      waddr_q <= route_map_pkg::word_of(s_axi_awaddr_i);
    end
    if (w_hs)
    begin
      wdata_q <= s_axi_wdata_i;
      wstrb_q <= s_axi_wstrb_i;
    end
  end

  assign wr_word_o = waddr_q;
  assign wr_data_o = wdata_q;
  assign wr_strb_o = wstrb_q;

  assign s_axi_bvalid_o = bvalid_q;
  assign s_axi_bresp_o  = axi_lite_pkg::RESP_OKAY;

endmodule

`default_nettype wire

// File: hw/route_cfg_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_regs_cfg.svh"

// storage of the routing configuration
// region words sit at index master*4*N_REGION + region*4 + slot
// map words sit at index 0x400 + slave, that is byte address 0x1000 and up
module route_cfg_regfile (
  input  wire logic                 s_axi_aclk,
  input  wire logic                 s_axi_aresetn,
  input  wire logic                 wr_en_i,
  input  route_map_pkg::word_addr_t wr_word_i,
  input  axi_lite_pkg::data_t       wr_data_i,
  input  axi_lite_pkg::strb_t       wr_strb_i,
  input  route_map_pkg::word_addr_t rd_word_i,
  output axi_lite_pkg::data_t       rd_data_o,
  input  axi_lite_pkg::addr_t [`AXI_REGS_N_REGION-1:0][`AXI_REGS_N_MASTER-1:0] init_start_addr_i,
  input  axi_lite_pkg::addr_t [`AXI_REGS_N_REGION-1:0][`AXI_REGS_N_MASTER-1:0] init_end_addr_i,
  input  wire logic [`AXI_REGS_N_REGION-1:0][`AXI_REGS_N_MASTER-1:0]           init_valid_rule_i,
  input  wire logic [`AXI_REGS_N_SLAVE-1:0][`AXI_REGS_N_MASTER-1:0]            init_conn_map_i,
  output axi_lite_pkg::addr_t [`AXI_REGS_N_REGION-1:0][`AXI_REGS_N_MASTER-1:0] start_addr_o,
  output axi_lite_pkg::addr_t [`AXI_REGS_N_REGION-1:0][`AXI_REGS_N_MASTER-1:0] end_addr_o,
  output logic [`AXI_REGS_N_REGION-1:0][`AXI_REGS_N_MASTER-1:0]                valid_rule_o,
  output logic [`AXI_REGS_N_SLAVE-1:0][`AXI_REGS_N_MASTER-1:0]                 conn_map_o
);

  localparam int N_MASTER = `AXI_REGS_N_MASTER;
  localparam int N_REGION = `AXI_REGS_N_REGION;
  localparam int N_SLAVE  = `AXI_REGS_N_SLAVE;
  localparam int STRB_W   = $bits(axi_lite_pkg::strb_t);

  // the reserved fourth slot of a region has no storage at all
  axi_lite_pkg::addr_t [N_REGION-1:0][N_MASTER-1:0] start_q;
  axi_lite_pkg::addr_t [N_REGION-1:0][N_MASTER-1:0] end_q;
  logic [N_REGION-1:0][N_MASTER-1:0]                valid_q;
  logic [N_SLAVE-1:0][N_MASTER-1:0]                 map_q;

  // read-modify-write image of the word being written
  route_map_pkg::cfg_word_u wr_new;
  route_map_pkg::cfg_word_u rd_word;

  // map words only exist for the configured slave ports
  function automatic logic is_map(input route_map_pkg::word_addr_t w);
    return w[route_map_pkg::MAP_SEL_BIT] && (int'(w[9:0]) < N_SLAVE);
  endfunction

  // region rows beyond the last master are unmapped
  function automatic logic is_region(input route_map_pkg::word_addr_t w);
    return !w[route_map_pkg::MAP_SEL_BIT] && (int'(w[9:2]) < N_MASTER * N_REGION);
  endfunction

  function automatic route_map_pkg::slot_e slot_of(input route_map_pkg::word_addr_t w);
    return route_map_pkg::slot_e'(w[1:0]);
  endfunction

  function automatic int master_of(input route_map_pkg::word_addr_t w);
    return int'(w[9:2]) / N_REGION;
  endfunction

  function automatic int region_of(input route_map_pkg::word_addr_t w);
    return int'(w[9:2]) % N_REGION;
  endfunction

  // current contents of a word, zero for reserved and unmapped locations
  function automatic route_map_pkg::cfg_word_u read_word(input route_map_pkg::word_addr_t w);
    route_map_pkg::cfg_word_u word;
    word = '0;
    if (is_map(w))
    begin
      word.addr[N_MASTER-1:0] = map_q[int'(w[9:0])];
    end
    else if (is_region(w))
    begin
      case (slot_of(w))
        route_map_pkg::SLOT_START: word.addr = start_q[region_of(w)][master_of(w)];
        route_map_pkg::SLOT_END:   word.addr = end_q[region_of(w)][master_of(w)];
        route_map_pkg::SLOT_RULE:  word.rule.valid = valid_q[region_of(w)][master_of(w)];
        default:                   word = '0;
      endcase
    end
    return word;
  endfunction

  // strobes merge byte lanes into the old word
  // for rule and map words only the stored low bits are kept afterwards
  always_comb
  begin
    wr_new = read_word(wr_word_i);
    for (int b = 0; b < STRB_W; b++)
    begin
      if (wr_strb_i[b])
      begin
        wr_new.addr[b*8 +: 8] = wr_data_i[b*8 +: 8];
      end
    end
  end

  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn)
  begin
    if (!s_axi_aresetn)
    begin
      start_q <= init_start_addr_i;
      end_q   <= init_end_addr_i;
      valid_q <= init_valid_rule_i;
      map_q   <= init_conn_map_i;
    end
    else if (wr_en_i)
    begin
      if (is_map(wr_word_i))
      begin
        map_q[int'(wr_word_i[9:0])] <= wr_new.addr[N_MASTER-1:0];
      end
      else if (is_region(wr_word_i))
      begin
        case (slot_of(wr_word_i))
          route_map_pkg::SLOT_START:
            start_q[region_of(wr_word_i)][master_of(wr_word_i)] <= wr_new.addr;
          route_map_pkg::SLOT_END:
            end_q[region_of(wr_word_i)][master_of(wr_word_i)] <= wr_new.addr;
          route_map_pkg::SLOT_RULE:
            valid_q[region_of(wr_word_i)][master_of(wr_word_i)] <= wr_new.rule.valid;
          default:
          begin
          end
        endcase
      end
    end
  end

  always_comb
  begin
    rd_word = read_word(rd_word_i);
  end

  assign rd_data_o = rd_word;

  // routing logic sees the storage directly
  assign start_addr_o = start_q;
  assign end_addr_o   = end_q;
  assign valid_rule_o = valid_q;
  assign conn_map_o   = map_q;

endmodule

`default_nettype wire

// File: hw/axi_lite_read_port.sv
`timescale 1ns/1ps
`default_nettype none

// AXI-Lite read side of the configuration block
// one read is in flight at a time, R is held until it is taken
module axi_lite_read_port (
  input  wire logic                 s_axi_aclk,
  input  wire logic                 s_axi_aresetn,
  input  axi_lite_pkg::addr_t       s_axi_araddr_i,
  input  wire logic                 s_axi_arvalid_i,
  output logic                      s_axi_arready_o,
  output logic                      s_axi_rvalid_o,
  output axi_lite_pkg::data_t       s_axi_rdata_o,
  output axi_lite_pkg::resp_t       s_axi_rresp_o,
  input  wire logic                 s_axi_rready_i,
  output route_map_pkg::word_addr_t rd_word_o,
  input  axi_lite_pkg::data_t       rd_data_i
);

  logic ar_done_q;
  logic rvalid_q;
  // high for the one cycle after the R handshake
  logic r_done_q;

  logic ar_hs;
  logic r_hs;
  logic fetch;

  route_map_pkg::word_addr_t raddr_q;
  axi_lite_pkg::data_t       rdata_q;

  assign ar_hs = s_axi_arvalid_i && !ar_done_q;
  assign r_hs  = rvalid_q && s_axi_rready_i;
  // the cycle after AR the word is sampled and rvalid rises
  assign fetch = ar_done_q && !rvalid_q && !r_done_q;

  always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn)
  begin
    if (!s_axi_aresetn)
    begin
      ar_done_q <= 1'b0;
      rvalid_q  <= 1'b0;
      r_done_q  <= 1'b0;
    end
    else
    begin
      if (ar_hs)
      begin
        ar_done_q <= 1'b1;
      end
      else if (r_done_q)
      begin
        ar_done_q <= 1'b0;
      end

      if (fetch)
      begin
        rvalid_q <= 1'b1;
      end
      else if (r_hs)
      begin
        rvalid_q <= 1'b0;
      end

      r_done_q <= r_hs;
    end
  end

  // the sampled word is held so a later write cannot change R mid-transfer
  always_ff @(posedge s_axi_aclk)
  begin
    if (ar_hs)
    begin
      raddr_q <= route_map_pkg::word_of(s_axi_araddr_i);
    end
    if (fetch)
    begin
      rdata_q <= rd_data_i;
    end
  end

  assign rd_word_o       = raddr_q;
  assign s_axi_arready_o = !ar_done_q;
  assign s_axi_rvalid_o  = rvalid_q;
  assign s_axi_rdata_o   = rdata_q;
  assign s_axi_rresp_o   = axi_lite_pkg::RESP_OKAY;

endmodule

`default_nettype wire

// File: hw/axi_regs_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_regs_cfg.svh"

// configuration register block of an AXI interconnect node
// software writes region and connectivity words over AXI-Lite
// the stored values drive the routing logic in parallel
module axi_regs_top (
  input  wire logic                 s_axi_aclk,
  input  wire logic                 s_axi_aresetn,
  // write address and write data channels
  input  axi_lite_pkg::addr_t       s_axi_awaddr_i,
  input  wire logic                 s_axi_awvalid_i,
  output logic                      s_axi_awready_o,
  input  axi_lite_pkg::data_t       s_axi_wdata_i,
  input  axi_lite_pkg::strb_t       s_axi_wstrb_i,
  input  wire logic                 s_axi_wvalid_i,
  output logic                      s_axi_wready_o,
  // write response channel
  output axi_lite_pkg::resp_t       s_axi_bresp_o,
  output logic                      s_axi_bvalid_o,
  input  wire logic                 s_axi_bready_i,
  // read address and read data channels
  input  axi_lite_pkg::addr_t       s_axi_araddr_i,
  input  wire logic                 s_axi_arvalid_i,
  output logic                      s_axi_arready_o,
  output axi_lite_pkg::data_t       s_axi_rdata_o,
  output axi_lite_pkg::resp_t       s_axi_rresp_o,
  output logic                      s_axi_rvalid_o,
  input  wire logic                 s_axi_rready_i,
  // values loaded at reset, indexed by region then master
  input  axi_lite_pkg::addr_t [`AXI_REGS_N_REGION-1:0][`AXI_REGS_N_MASTER-1:0] init_start_addr_i,
  input  axi_lite_pkg::addr_t [`AXI_REGS_N_REGION-1:0][`AXI_REGS_N_MASTER-1:0] init_end_addr_i,
  input  wire logic [`AXI_REGS_N_REGION-1:0][`AXI_REGS_N_MASTER-1:0]           init_valid_rule_i,
  input  wire logic [`AXI_REGS_N_SLAVE-1:0][`AXI_REGS_N_MASTER-1:0]            init_conn_map_i,
  // live configuration towards the routing logic
  output axi_lite_pkg::addr_t [`AXI_REGS_N_REGION-1:0][`AXI_REGS_N_MASTER-1:0] start_addr_o,
  output axi_lite_pkg::addr_t [`AXI_REGS_N_REGION-1:0][`AXI_REGS_N_MASTER-1:0] end_addr_o,
  output logic [`AXI_REGS_N_REGION-1:0][`AXI_REGS_N_MASTER-1:0]                valid_rule_o,
  output logic [`AXI_REGS_N_SLAVE-1:0][`AXI_REGS_N_MASTER-1:0]                 conn_map_o
);

  // one write per B response, presented for a single cycle
  logic                      wr_en;
  route_map_pkg::word_addr_t wr_word;
  axi_lite_pkg::data_t       wr_data;
  axi_lite_pkg::strb_t       wr_strb;
  // read index held by the read port, data returns in the same cycle
  route_map_pkg::word_addr_t rd_word;
  axi_lite_pkg::data_t       rd_data;

  axi_lite_write_port write_port_inst (
    .s_axi_aclk      (s_axi_aclk),
    .s_axi_aresetn   (s_axi_aresetn),
    .s_axi_awaddr_i  (s_axi_awaddr_i),
    .s_axi_awvalid_i (s_axi_awvalid_i),
    .s_axi_awready_o (s_axi_awready_o),
    .s_axi_wdata_i   (s_axi_wdata_i),
    .s_axi_wstrb_i   (s_axi_wstrb_i),
    .s_axi_wvalid_i  (s_axi_wvalid_i),
    .s_axi_wready_o  (s_axi_wready_o),
    .s_axi_bvalid_o  (s_axi_bvalid_o),
    .s_axi_bresp_o   (s_axi_bresp_o),
    .s_axi_bready_i  (s_axi_bready_i),
    .wr_en_o         (wr_en),
    .wr_word_o       (wr_word),
    .wr_data_o       (wr_data),
    .wr_strb_o       (wr_strb)
  );

  route_cfg_regfile regfile_inst (
    .s_axi_aclk        (s_axi_aclk),
    .s_axi_aresetn     (s_axi_aresetn),
    .wr_en_i           (wr_en),
    .wr_word_i         (wr_word),
    .wr_data_i         (wr_data),
    .wr_strb_i         (wr_strb),
    .rd_word_i         (rd_word),
    .rd_data_o         (rd_data),
    .init_start_addr_i (init_start_addr_i),
    .init_end_addr_i   (init_end_addr_i),
    .init_valid_rule_i (init_valid_rule_i),
    .init_conn_map_i   (init_conn_map_i),
    .start_addr_o      (start_addr_o),
    .end_addr_o        (end_addr_o),
    .valid_rule_o      (valid_rule_o),
    .conn_map_o        (conn_map_o)
  );

  axi_lite_read_port read_port_inst (
    .s_axi_aclk      (s_axi_aclk),
    .s_axi_aresetn   (s_axi_aresetn),
    .s_axi_araddr_i  (s_axi_araddr_i),
    .s_axi_arvalid_i (s_axi_arvalid_i),
    .s_axi_arready_o (s_axi_arready_o),
    .s_axi_rvalid_o  (s_axi_rvalid_o),
    .s_axi_rdata_o   (s_axi_rdata_o),
    .s_axi_rresp_o   (s_axi_rresp_o),
    .s_axi_rready_i  (s_axi_rready_i),
    .rd_word_o       (rd_word),
    .rd_data_i       (rd_data)
  );

endmodule

`default_nettype wire

// File: sim/axi_regs_assert.sv
`timescale 1ns/1ps
`default_nettype none

// handshake properties of the AXI-Lite slave port of the configuration block
module axi_regs_assert (
  input wire logic          s_axi_aclk,
  input wire logic          s_axi_aresetn,
  input wire logic          s_axi_awready_i,
  input wire logic          s_axi_wready_i,
  input wire logic          s_axi_bvalid_i,
  input wire logic          s_axi_bready_i,
  input wire logic          s_axi_arready_i,
  input wire logic          s_axi_rvalid_i,
  input wire logic          s_axi_rready_i,
  input axi_lite_pkg::data_t s_axi_rdata_i
);

  // a response stays up until the master takes it
  b_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    s_axi_bvalid_i && !s_axi_bready_i |=> s_axi_bvalid_i)
    else $error("bvalid dropped before its handshake");

  r_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    s_axi_rvalid_i && !s_axi_rready_i |=> s_axi_rvalid_i)
    else $error("rvalid dropped before its handshake");

  // both readies are low once AW and W are captured, so B can only follow them
  b_after_aw_w: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    $rose(s_axi_bvalid_i) |-> !s_axi_awready_i && !s_axi_wready_i)
    else $error("bvalid rose before both AW and W were accepted");

  r_stable: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    s_axi_rvalid_i && $past(s_axi_rvalid_i) |-> $stable(s_axi_rdata_i))
    else $error("rdata changed while rvalid was high");

  // the address channels open as soon as reset is released
  ready_after_reset: assert property (@(posedge s_axi_aclk)
    $rose(s_axi_aresetn) |-> s_axi_awready_i && s_axi_wready_i && s_axi_arready_i)
    else $error("a ready signal was low right after reset");

endmodule

bind axi_regs_top axi_regs_assert axi_regs_assert_inst (
  .s_axi_aclk      (s_axi_aclk),
  .s_axi_aresetn   (s_axi_aresetn),
  .s_axi_awready_i (s_axi_awready_o),
  .s_axi_wready_i  (s_axi_wready_o),
  .s_axi_bvalid_i  (s_axi_bvalid_o),
  .s_axi_bready_i  (s_axi_bready_i),
  .s_axi_arready_i (s_axi_arready_o),
  .s_axi_rvalid_i  (s_axi_rvalid_o),
  .s_axi_rready_i  (s_axi_rready_i),
  .s_axi_rdata_i   (s_axi_rdata_o)
);

`default_nettype wire

// File: sim/tb_axi_regs_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_regs_cfg.svh"

// testbench for the routing configuration block
// random AXI-Lite traffic is checked against a word model of the register map
module tb_axi_regs_top;

  localparam int N_MASTER = `AXI_REGS_N_MASTER;
  localparam int N_REGION = `AXI_REGS_N_REGION;
  localparam int N_SLAVE  = `AXI_REGS_N_SLAVE;
  localparam int STRB_W   = $bits(axi_lite_pkg::strb_t);
  // word index of the first connectivity map word, byte address 0x1000
  localparam int MAP_BASE = 1024;
  localparam int TIMEOUT  = 64;
  localparam int N_RAND   = 60;
  localparam int SEL_AWREADY = 0;
  localparam int SEL_WREADY  = 1;
  localparam int SEL_ARREADY = 2;
  localparam int SEL_BVALID  = 3;
  localparam int SEL_RVALID  = 4;
  // AXI response code OKAY
  localparam logic [1:0] OKAY_RESP = 2'b00;

  typedef logic [N_MASTER-1:0] mask_t;

  logic                s_axi_aclk;
  logic                s_axi_aresetn;
  axi_lite_pkg::addr_t awaddr;
  logic                awvalid;
  logic                awready;
  axi_lite_pkg::data_t wdata;
  axi_lite_pkg::strb_t wstrb;
  logic                wvalid;
  logic                wready;
  axi_lite_pkg::resp_t bresp;
  logic                bvalid;
  logic                bready;
  axi_lite_pkg::addr_t araddr;
  logic                arvalid;
  logic                arready;
  axi_lite_pkg::data_t rdata;
  axi_lite_pkg::resp_t rresp;
  logic                rvalid;
  logic                rready;

  axi_lite_pkg::addr_t [N_REGION-1:0][N_MASTER-1:0] init_start;
  axi_lite_pkg::addr_t [N_REGION-1:0][N_MASTER-1:0] init_end;
  logic [N_REGION-1:0][N_MASTER-1:0]                init_valid;
  logic [N_SLAVE-1:0][N_MASTER-1:0]                 init_map;
  axi_lite_pkg::addr_t [N_REGION-1:0][N_MASTER-1:0] start_out;
  axi_lite_pkg::addr_t [N_REGION-1:0][N_MASTER-1:0] end_out;
  logic [N_REGION-1:0][N_MASTER-1:0]                valid_out;
  logic [N_SLAVE-1:0][N_MASTER-1:0]                 map_out;

  // one model word per word index, reserved and unmapped words stay zero
  route_map_pkg::cfg_word_u model_mem [0:2047];
  string test_name;
  int    checks;
  int    errors;
  int    timeouts;
  // widest random gap and back-pressure stall, in cycles
  int    max_gap;

  axi_regs_top axi_regs_top_inst (
    .s_axi_aclk        (s_axi_aclk),
    .s_axi_aresetn     (s_axi_aresetn),
    .s_axi_awaddr_i    (awaddr),
    .s_axi_awvalid_i   (awvalid),
    .s_axi_awready_o   (awready),
    .s_axi_wdata_i     (wdata),
    .s_axi_wstrb_i     (wstrb),
    .s_axi_wvalid_i    (wvalid),
    .s_axi_wready_o    (wready),
    .s_axi_bresp_o     (bresp),
    .s_axi_bvalid_o    (bvalid),
    .s_axi_bready_i    (bready),
    .s_axi_araddr_i    (araddr),
    .s_axi_arvalid_i   (arvalid),
    .s_axi_arready_o   (arready),
    .s_axi_rdata_o     (rdata),
    .s_axi_rresp_o     (rresp),
    .s_axi_rvalid_o    (rvalid),
    .s_axi_rready_i    (rready),
    .init_start_addr_i (init_start),
    .init_end_addr_i   (init_end),
    .init_valid_rule_i (init_valid),
    .init_conn_map_i   (init_map),
    .start_addr_o      (start_out),
    .end_addr_o        (end_out),
    .valid_rule_o      (valid_out),
    .conn_map_o        (map_out)
  );

  initial
  begin
    s_axi_aclk = 1'b0;
    forever #50 s_axi_aclk = ~s_axi_aclk;
  end

  // inputs change a fixed delay after the rising edge
  task automatic next_cycle();
    @(posedge s_axi_aclk);
    #10;
  endtask

  task automatic check_value(input string what, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    checks++;
    assert (act_v === exp_v)
    else
    begin
      errors++;
      $display("[ERROR] %s: %s expected %h actual %h", test_name, what, exp_v, act_v);
    end
  endtask

  function automatic logic out_level(input int sel);
    case (sel)
      SEL_AWREADY: return awready;
      SEL_WREADY:  return wready;
      SEL_ARREADY: return arready;
      SEL_BVALID:  return bvalid;
      default:     return rvalid;
    endcase
  endfunction

  // outputs are looked at on falling edges, half a cycle away from any change
  // returns on the falling edge before the handshake edge
  task automatic wait_output(input int sel, input string what);
    int waited;
    waited = 0;
    @(negedge s_axi_aclk);
    while (!out_level(sel) && waited < TIMEOUT)
    begin
      @(negedge s_axi_aclk);
      waited++;
    end
    if (!out_level(sel))
    begin
      timeouts++;
      $display("timeout in %s: %s did not go high within %0d cycles", test_name, what, TIMEOUT);
    end
  endtask

  // word index of a byte address, bits 12 down to 2
  function automatic route_map_pkg::word_addr_t word_idx(input axi_lite_pkg::addr_t addr);
    return addr[12:2];
  endfunction

  function automatic axi_lite_pkg::addr_t region_addr(input int m, input int r, input int slot);
    return axi_lite_pkg::addr_t'(((m * N_REGION + r) * 4 + slot) * 4);
  endfunction

  function automatic axi_lite_pkg::addr_t map_addr(input int s);
    return axi_lite_pkg::addr_t'((MAP_BASE + s) * 4);
  endfunction

  function automatic axi_lite_pkg::addr_t random_mapped();
    int kind;
    kind = $urandom_range(3);
    if (kind == 3)
    begin
      return map_addr($urandom_range(N_SLAVE - 1));
    end
    return region_addr($urandom_range(N_MASTER - 1), $urandom_range(N_REGION - 1), kind);
  endfunction

  // reserved slots, region rows past the last master and map words past the last slave
  function automatic axi_lite_pkg::addr_t random_unmapped();
    int kind;
    int word;
    kind = $urandom_range(2);
    if (kind == 0)
    begin
      return region_addr($urandom_range(N_MASTER - 1), $urandom_range(N_REGION - 1), 3);
    end
    if (kind == 1)
    begin
      word = $urandom_range(MAP_BASE - 1, N_MASTER * N_REGION * 4);
    end
    else
    begin
      word = $urandom_range(2047, MAP_BASE + N_SLAVE);
    end
    return axi_lite_pkg::addr_t'(word * 4);
  endfunction

  // start and end words take strobed bytes, rule and map words only strobe 0
  task automatic model_write(input axi_lite_pkg::addr_t addr, input axi_lite_pkg::data_t data,
                             input axi_lite_pkg::strb_t strb);
    route_map_pkg::word_addr_t w;
    int row;
    w   = word_idx(addr);
    row = int'(w[9:2]);
    if (w[10])
    begin
      if (int'(w[9:0]) < N_SLAVE && strb[0])
      begin
        model_mem[w].addr[N_MASTER-1:0] = data[N_MASTER-1:0];
      end
    end
    else if (row < N_MASTER * N_REGION)
    begin
      case (route_map_pkg::slot_e'(w[1:0]))
        route_map_pkg::SLOT_START, route_map_pkg::SLOT_END:
        begin
          for (int b = 0; b < STRB_W; b++)
          begin
            if (strb[b])
            begin
              model_mem[w].addr[b*8 +: 8] = data[b*8 +: 8];
            end
          end
        end
        route_map_pkg::SLOT_RULE:
        begin
          if (strb[0])
          begin
            model_mem[w].rule.valid = data[0];
          end
        end
        default:
        begin
        end
      endcase
    end
  endtask

  task automatic send_aw(input axi_lite_pkg::addr_t addr, input int gap);
    repeat (gap) next_cycle();
    awaddr  = addr;
    awvalid = 1'b1;
    wait_output(SEL_AWREADY, "awready");
    next_cycle();
    awvalid = 1'b0;
  endtask

  task automatic send_w(input axi_lite_pkg::data_t data, input axi_lite_pkg::strb_t strb,
                        input int gap);
    repeat (gap) next_cycle();
    wdata  = data;
    wstrb  = strb;
    wvalid = 1'b1;
    wait_output(SEL_WREADY, "wready");
    next_cycle();
    wvalid = 1'b0;
  endtask

  // AW and W run side by side with their own gaps, so either may land first
  task automatic write_word(input axi_lite_pkg::addr_t addr, input axi_lite_pkg::data_t data,
                            input axi_lite_pkg::strb_t strb);
    int aw_gap;
    int w_gap;
    int hold;
    aw_gap = $urandom_range(max_gap);
    w_gap  = $urandom_range(max_gap);
    hold   = $urandom_range(max_gap + 2);
    fork
      send_aw(addr, aw_gap);
      send_w(data, strb, w_gap);
    join
    repeat (hold) next_cycle();
    bready = 1'b1;
    wait_output(SEL_BVALID, "bvalid");
    check_value("bresp", 32'(OKAY_RESP), 32'(bresp));
    next_cycle();
    bready = 1'b0;
    // a second response would show as bvalid still high here
    @(negedge s_axi_aclk);
    check_value("bvalid after B", 32'd0, 32'(bvalid));
    next_cycle();
    model_write(addr, data, strb);
  endtask

  task automatic check_read(input axi_lite_pkg::addr_t addr);
    int gap;
    int hold;
    gap  = $urandom_range(max_gap);
    hold = $urandom_range(max_gap + 2);
    repeat (gap) next_cycle();
    araddr  = addr;
    arvalid = 1'b1;
    wait_output(SEL_ARREADY, "arready");
    next_cycle();
    arvalid = 1'b0;
    repeat (hold) next_cycle();
    rready = 1'b1;
    wait_output(SEL_RVALID, "rvalid");
    check_value($sformatf("rdata at %h", addr), model_mem[word_idx(addr)].addr, rdata);
    check_value("rresp", 32'(OKAY_RESP), 32'(rresp));
    next_cycle();
    rready = 1'b0;
    @(negedge s_axi_aclk);
    check_value("rvalid after R", 32'd0, 32'(rvalid));
    next_cycle();
  endtask

  task automatic check_outputs();
    for (int r = 0; r < N_REGION; r++)
    begin
      for (int m = 0; m < N_MASTER; m++)
      begin
        check_value($sformatf("start_addr_o[%0d][%0d]", r, m),
                    model_mem[word_idx(region_addr(m, r, 0))].addr, start_out[r][m]);
        check_value($sformatf("end_addr_o[%0d][%0d]", r, m),
                    model_mem[word_idx(region_addr(m, r, 1))].addr, end_out[r][m]);
        check_value($sformatf("valid_rule_o[%0d][%0d]", r, m),
                    model_mem[word_idx(region_addr(m, r, 2))].addr, 32'(valid_out[r][m]));
      end
    end
    for (int s = 0; s < N_SLAVE; s++)
    begin
      check_value($sformatf("conn_map_o[%0d]", s),
                  model_mem[word_idx(map_addr(s))].addr, 32'(map_out[s]));
    end
  endtask

  initial
  begin
    axi_lite_pkg::addr_t addr;
    void'($urandom(32'h3d6b83cc));
    checks   = 0;
    errors   = 0;
    timeouts = 0;
    max_gap  = 2;
    s_axi_aresetn = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    for (int i = 0; i < 2048; i++)
    begin
      model_mem[i] = '0;
    end
    // random init values, mirrored into the model word by word
    for (int r = 0; r < N_REGION; r++)
    begin
      for (int m = 0; m < N_MASTER; m++)
      begin
        init_start[r][m] = $urandom();
        init_end[r][m]   = $urandom();
        init_valid[r][m] = 1'($urandom_range(1));
        model_mem[word_idx(region_addr(m, r, 0))].addr = init_start[r][m];
        model_mem[word_idx(region_addr(m, r, 1))].addr = init_end[r][m];
        model_mem[word_idx(region_addr(m, r, 2))].addr = 32'(init_valid[r][m]);
      end
    end
    for (int s = 0; s < N_SLAVE; s++)
    begin
      init_map[s] = mask_t'($urandom());
      model_mem[word_idx(map_addr(s))].addr = 32'(init_map[s]);
    end
    repeat (3) @(posedge s_axi_aclk);
    #10;
    s_axi_aresetn = 1'b1;

    test_name = "reset_values";
    check_outputs();
    for (int m = 0; m < N_MASTER; m++)
    begin
      for (int r = 0; r < N_REGION; r++)
      begin
        for (int slot = 0; slot < 3; slot++)
        begin
          check_read(region_addr(m, r, slot));
        end
      end
    end
    for (int s = 0; s < N_SLAVE; s++)
    begin
      check_read(map_addr(s));
    end

    test_name = "full_strobe";
    repeat (N_RAND)
    begin
      addr = random_mapped();
      write_word(addr, $urandom(), '1);
      check_read(addr);
      check_outputs();
    end

    test_name = "partial_strobe";
    repeat (N_RAND)
    begin
      addr = random_mapped();
      write_word(addr, $urandom(), axi_lite_pkg::strb_t'($urandom()));
      check_read(addr);
      check_outputs();
    end

    // the model never changes here, so any DUT change shows as a mismatch
    test_name = "unmapped";
    repeat (N_RAND)
    begin
      addr = random_unmapped();
      check_read(addr);
      write_word(addr, $urandom(), axi_lite_pkg::strb_t'($urandom()));
      check_read(addr);
      check_outputs();
    end

    // longer gaps and stalls, reads and writes to any word in random order
    test_name = "mixed_traffic";
    max_gap   = 6;
    repeat (2 * N_RAND)
    begin
      addr = ($urandom_range(3) == 0) ? random_unmapped() : random_mapped();
      if ($urandom_range(1) == 1)
      begin
        write_word(addr, $urandom(), axi_lite_pkg::strb_t'($urandom()));
      end
      else
      begin
        check_read(addr);
      end
    end
    check_outputs();

    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0)
    begin
      $display("ALL TESTS PASSED");
    end
    else
    begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+hw
hw/axi_lite_pkg.sv
hw/route_map_pkg.sv
hw/axi_lite_write_port.sv
hw/route_cfg_regfile.sv
hw/axi_lite_read_port.sv
hw/axi_regs_top.sv
sim/axi_regs_assert.sv
sim/tb_axi_regs_top.sv

// File: run_sim.sh
#!/bin/sh
# compiles the testbench with Verilator, runs it and scans the log for failures

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module tb_axi_regs_top -f tb.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/Vtb_axi_regs_top > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "SOME TESTS FAILED" "$log"; then
  echo "failure reported in $log"
  exit 1
fi

echo "no failure reported in $log"
exit 0
